// File: dv/mmu_stimulus.txt
# P <pte address> <pte>   F = flush pulse   all values hex
# C <store> <vaddr> <priv> <sum> <satp_mode> <satp_ppn> <miss> <paddr> <lpf> <spf> <af>
P 000100004 00040401
P 000100008 00080003
P 00010000c 00040801
P 000100010 0004c0fe
P 000101000 000800d7
P 000101004 000804c7
P 000101008 000808c3
P 00010100c 00080c47
P 000101010 400810c7
P 000102000 00040c01
# bare mode and machine mode
C 0 12345678 1 0 0 00100 0 012345678 0 0 0
C 1 89abcdef 3 0 1 00100 0 089abcdef 0 0 0
# first access walks, second one hits
C 0 00400123 0 0 1 00100 1 000200123 0 0 0
C 1 00400ff8 0 0 1 00100 0 000200ff8 0 0 0
# privilege, write and dirty rules
C 0 00401010 0 0 1 00100 1 000201010 1 0 0
C 0 00400200 1 0 1 00100 0 000200200 1 0 0
C 0 00400200 1 1 1 00100 0 000200200 0 0 0
C 1 00400204 1 0 1 00100 0 000200204 0 1 0
C 1 00402008 1 0 1 00100 1 000202008 0 1 0
C 0 0040200c 1 0 1 00100 0 00020200c 0 0 0
C 1 00403000 1 0 1 00100 1 000203000 0 1 0
C 0 00403004 1 0 1 00100 0 000203004 0 0 0
# domain access fault
C 0 00404abc 1 0 1 00100 1 100204abc 0 0 1
# invalid PTE, level-1 leaf, level-0 pointer
C 0 01000000 1 0 1 00100 1 000000000 1 0 0
C 1 00800010 1 0 1 00100 1 000000000 0 1 0
C 0 00c00000 0 0 1 00100 1 000000000 1 0 0
# flush, then round-robin eviction over five pages
C 0 00401000 1 0 1 00100 0 000201000 0 0 0
F
C 0 00401004 1 0 1 00100 1 000201004 0 0 0
C 0 00402000 1 0 1 00100 1 000202000 0 0 0
C 0 00403000 1 0 1 00100 1 000203000 0 0 0
C 0 00400000 0 0 1 00100 1 000200000 0 0 0
C 0 00404000 1 0 1 00100 1 100204000 0 0 1
C 0 00401008 1 0 1 00100 1 000201008 0 0 0
C 0 00403008 1 0 1 00100 0 000203008 0 0 0

// File: src.f
hw/mmu_pkg.sv
hw/ptw_req_if.sv
hw/dtlb.sv
hw/walk_level_counter.sv
hw/ptw_fsm.sv
hw/mmu_pipe.sv
hw/mmu_top.sv
dv/mmu_tb.sv

// File: Bender.yml
package:
  name: dside_mmu

sources:
  - files:
      - hw/mmu_pkg.sv
      - hw/ptw_req_if.sv
      - hw/dtlb.sv
      - hw/walk_level_counter.sv
      - hw/ptw_fsm.sv
      - hw/mmu_pipe.sv
      - hw/mmu_top.sv
  - target: test
    files:
      - dv/mmu_tb.sv

// File: dv/mmu_tb.sv
/*
 * Testbench for the data-side MMU
 * Page table memory model, command driver with replay, response checks
 */
`timescale 1ns/1ps

module mmu_tb;
  import mmu_pkg::*;

  localparam int TIMEOUT_CYCLES = 200;
  localparam int PT_DEPTH       = 32;

  logic               clk_i;
  logic               reset_i;
  logic               cmd_v_i;
  logic               cmd_store_i;
  logic [VADDR_W-1:0] cmd_vaddr_i;
  priv_e              priv_i;
  logic               sum_i;
  logic               satp_mode_i;
  ppn_t               satp_ppn_i;
  logic               flush_i;
  logic               cmd_ready_o;
  logic               resp_v_o;
  paddr_t             resp_paddr_o;
  logic               resp_miss_o;
  logic               resp_load_page_fault_o;
  logic               resp_store_page_fault_o;
  logic               resp_access_fault_o;
  logic               walk_req_v_o;
  paddr_t             walk_req_addr_o;
  logic               walk_resp_v_i;
  pte_t               walk_resp_data_i;

  // Page table image from the stimulus file
  paddr_t pt_addr [PT_DEPTH];
  pte_t   pt_data [PT_DEPTH];
  int     pt_count;

  mmu_top #(
    .TLB_ENTRIES (4)
  ) i_mmu_top (
    .clk_i                   (clk_i),
    .reset_i                 (reset_i),
    .cmd_v_i                 (cmd_v_i),
    .cmd_store_i             (cmd_store_i),
    .cmd_vaddr_i             (cmd_vaddr_i),
    .priv_i                  (priv_i),
    .sum_i                   (sum_i),
    .satp_mode_i             (satp_mode_i),
    .satp_ppn_i              (satp_ppn_i),
    .flush_i                 (flush_i),
    .cmd_ready_o             (cmd_ready_o),
    .resp_v_o                (resp_v_o),
    .resp_paddr_o            (resp_paddr_o),
    .resp_miss_o             (resp_miss_o),
    .resp_load_page_fault_o  (resp_load_page_fault_o),
    .resp_store_page_fault_o (resp_store_page_fault_o),
    .resp_access_fault_o     (resp_access_fault_o),
    .walk_req_v_o            (walk_req_v_o),
    .walk_req_addr_o         (walk_req_addr_o),
    .walk_resp_v_i           (walk_resp_v_i),
    .walk_resp_data_i        (walk_resp_data_i)
  );

  always #4 clk_i = ~clk_i;

  task automatic stop_with_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_paddr(input string name, input paddr_t got, input paddr_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic compare_faults(input logic lpf, input logic spf, input logic af);
    check_flag("resp_load_page_fault_o", resp_load_page_fault_o, lpf);
    check_flag("resp_store_page_fault_o", resp_store_page_fault_o, spf);
    check_flag("resp_access_fault_o", resp_access_fault_o, af);
  endtask

  function automatic int find_pte(input paddr_t addr);
    int idx;
    idx = -1;
    for (int i = 0; i < pt_count; i++) begin
      if (pt_addr[i] == addr) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  // Issues one command and returns at the falling edge of the response cycle
  task automatic send_cmd(input logic store, input logic [VADDR_W-1:0] vaddr,
                          input priv_e priv, input logic sum, input logic mode,
                          input ppn_t satp_ppn);
    int waited;
    waited = 0;
    while (!cmd_ready_o) begin
      if (waited == TIMEOUT_CYCLES) begin
        stop_with_error("cmd_ready_o never went high for a new command");
      end
      @(negedge clk_i);
      waited++;
    end
    @(posedge clk_i);
    cmd_v_i     <= 1'b1;
    cmd_store_i <= store;
    cmd_vaddr_i <= vaddr;
    priv_i      <= priv;
    sum_i       <= sum;
    satp_mode_i <= mode;
    satp_ppn_i  <= satp_ppn;
    @(negedge clk_i);
    check_flag("resp_v_o", resp_v_o, 1'b0);
    @(posedge clk_i);
    cmd_v_i <= 1'b0;
    @(negedge clk_i);
    check_flag("resp_v_o", resp_v_o, 1'b1);
  endtask

  // Ends on a fault response or on cmd_ready_o after a fill
  task automatic wait_walk_end(output logic faulted);
    int waited;
    waited = 0;
    @(negedge clk_i);
    // Commands are held off from the cycle after the miss response
    check_flag("cmd_ready_o", cmd_ready_o, 1'b0);
    while (!resp_v_o && !cmd_ready_o) begin
      if (waited == TIMEOUT_CYCLES) begin
        stop_with_error("page table walk never ended with a fill or a fault");
      end
      @(negedge clk_i);
      waited++;
    end
    faulted = resp_v_o;
  endtask

  task automatic run_command(input logic store, input logic [VADDR_W-1:0] vaddr,
                             input priv_e priv, input logic sum, input logic mode,
                             input ppn_t satp_ppn, input logic exp_miss,
                             input paddr_t exp_paddr, input logic exp_lpf,
                             input logic exp_spf, input logic exp_af);
    logic faulted;
    send_cmd(store, vaddr, priv, sum, mode, satp_ppn);
    check_flag("resp_miss_o", resp_miss_o, exp_miss);
    if (exp_miss) begin
      // No fault can come without a hit
      compare_faults(1'b0, 1'b0, 1'b0);
      wait_walk_end(faulted);
      if (!faulted) begin
        send_cmd(store, vaddr, priv, sum, mode, satp_ppn);
      end
      check_flag("resp_miss_o", resp_miss_o, 1'b0);
    end
    check_paddr("resp_paddr_o", resp_paddr_o, exp_paddr);
    compare_faults(exp_lpf, exp_spf, exp_af);
  endtask

  task automatic pulse_flush();
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    @(negedge clk_i);
  endtask

  // Page table memory that answers each request after 1 to 4 cycles
  initial begin : walk_memory
    int unsigned seed_ret;
    int unsigned delay;
    int          idx;
    paddr_t      addr;
    walk_resp_v_i    = 1'b0;
    walk_resp_data_i = '0;
    seed_ret = $urandom(32'h8ac1c752);
    forever begin
      @(negedge clk_i);
      if (walk_req_v_o) begin
        addr  = walk_req_addr_o;
        delay = 1 + ($urandom % 4);
        idx   = find_pte(addr);
        if (idx < 0) begin
          stop_with_error("walk read an address with no page table entry");
        end else begin
          repeat (delay) @(posedge clk_i);
          walk_resp_v_i    <= 1'b1;
          walk_resp_data_i <= pt_data[idx];
          @(posedge clk_i);
          walk_resp_v_i <= 1'b0;
        end
      end
    end
  end

  initial begin : driver
    int                 fd;
    int                 code;
    logic               done;
    logic [7:0]         kind;
    logic [8*200-1:0]   rest;
    logic [PADDR_W-1:0] pa;
    logic [PTE_W-1:0]   pd;
    logic               st;
    logic [VADDR_W-1:0] va;
    logic [1:0]         pr;
    logic               su;
    logic               md;
    logic [PPN_W-1:0]   sp;
    logic               em;
    logic [PADDR_W-1:0] ep;
    logic               el;
    logic               es;
    logic               ea;
    clk_i       = 1'b0;
    reset_i     = 1'b1;
    cmd_v_i     = 1'b0;
    cmd_store_i = 1'b0;
    cmd_vaddr_i = '0;
    priv_i      = priv_u;
    sum_i       = 1'b0;
    satp_mode_i = 1'b0;
    satp_ppn_i  = '0;
    flush_i     = 1'b0;
    pt_count    = 0;
    fd = $fopen("dv/mmu_stimulus.txt", "r");
    if (fd == 0) begin
      stop_with_error("could not open dv/mmu_stimulus.txt");
    end
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_flag("cmd_ready_o", cmd_ready_o, 1'b1);
    check_flag("resp_v_o", resp_v_o, 1'b0);
    done = 1'b0;
    while (!done) begin
      code = $fscanf(fd, " %c", kind);
      if (code != 1) begin
        done = 1'b1;
      end else if (kind == "#") begin
        code = $fgets(rest, fd);
      end else if (kind == "P") begin
        code = $fscanf(fd, "%h %h", pa, pd);
        if (code != 2 || pt_count == PT_DEPTH) begin
          stop_with_error("bad page table line in the stimulus file");
        end
        pt_addr[pt_count] = pa;
        pt_data[pt_count] = pte_t'(pd);
        pt_count++;
      end else if (kind == "C") begin
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h",
                       st, va, pr, su, md, sp, em, ep, el, es, ea);
        if (code != 11) begin
          stop_with_error("bad command line in the stimulus file");
        end
        run_command(st, va, priv_e'(pr), su, md, sp, em, ep, el, es, ea);
      end else if (kind == "F") begin
        pulse_flush();
      end else begin
        stop_with_error("unknown line kind in the stimulus file");
      end
    end
    $fclose(fd);
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: hw/mmu_top.sv
/*
 * Data-side MMU top level
 * Translation stage, data TLB and page table walker
 */
`timescale 1ns/1ps

module mmu_top #(
  parameter int TLB_ENTRIES = 4
) (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        cmd_v_i,
  input  logic                        cmd_store_i,
  input  logic [mmu_pkg::VADDR_W-1:0] cmd_vaddr_i,
  input  mmu_pkg::priv_e              priv_i,
  input  logic                        sum_i,
  input  logic                        satp_mode_i,
  input  mmu_pkg::ppn_t               satp_ppn_i,
  input  logic                        flush_i,
  output logic                        cmd_ready_o,
  output logic                        resp_v_o,
  output mmu_pkg::paddr_t             resp_paddr_o,
  output logic                        resp_miss_o,
  output logic                        resp_load_page_fault_o,
  output logic                        resp_store_page_fault_o,
  output logic                        resp_access_fault_o,
  output logic                        walk_req_v_o,
  output mmu_pkg::paddr_t             walk_req_addr_o,
  input  logic                        walk_resp_v_i,
  input  mmu_pkg::pte_t               walk_resp_data_i
);
  import mmu_pkg::*;

  vtag_t      tlb_vtag;
  logic       tlb_hit;
  tlb_entry_t tlb_entry;
  logic       fill_v;
  vtag_t      fill_vtag;
  tlb_entry_t fill_entry;

  ptw_req_if i_ptw_req ();

  mmu_pipe i_mmu_pipe (
    .clk_i                   (clk_i),
    .reset_i                 (reset_i),
    .cmd_v_i                 (cmd_v_i),
    .cmd_store_i             (cmd_store_i),
    .cmd_vaddr_i             (cmd_vaddr_i),
    .priv_i                  (priv_i),
    .sum_i                   (sum_i),
    .satp_mode_i             (satp_mode_i),
    .flush_i                 (flush_i),
    .cmd_ready_o             (cmd_ready_o),
    .tlb_vtag_o              (tlb_vtag),
    .tlb_hit_i               (tlb_hit),
    .tlb_entry_i             (tlb_entry),
    .resp_v_o                (resp_v_o),
    .resp_paddr_o            (resp_paddr_o),
    .resp_miss_o             (resp_miss_o),
    .resp_load_page_fault_o  (resp_load_page_fault_o),
    .resp_store_page_fault_o (resp_store_page_fault_o),
    .resp_access_fault_o     (resp_access_fault_o),
    .ptw                     (i_ptw_req.pipe)
  );

  dtlb #(
    .TLB_ENTRIES (TLB_ENTRIES)
  ) i_dtlb (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .flush_i      (flush_i),
    .r_vtag_i     (tlb_vtag),
    .r_hit_o      (tlb_hit),
    .r_entry_o    (tlb_entry),
    .fill_v_i     (fill_v),
    .fill_vtag_i  (fill_vtag),
    .fill_entry_i (fill_entry)
  );

  ptw_fsm i_ptw_fsm (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .walk             (i_ptw_req.walker),
    .satp_ppn_i       (satp_ppn_i),
    .walk_req_v_o     (walk_req_v_o),
    .walk_req_addr_o  (walk_req_addr_o),
    .walk_resp_v_i    (walk_resp_v_i),
    .walk_resp_data_i (walk_resp_data_i),
    .fill_v_o         (fill_v),
    .fill_vtag_o      (fill_vtag),
    .fill_entry_o     (fill_entry)
  );

endmodule

// File: hw/mmu_pipe.sv
/*
 * Translation stage: command accept, permission and domain checks,
 * response register and walk request on a TLB miss
 */
`timescale 1ns/1ps

module mmu_pipe (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        cmd_v_i,
  input  logic                        cmd_store_i,
  input  logic [mmu_pkg::VADDR_W-1:0] cmd_vaddr_i,
  input  mmu_pkg::priv_e              priv_i,
  input  logic                        sum_i,
  input  logic                        satp_mode_i,
  input  logic                        flush_i,
  output logic                        cmd_ready_o,
  output mmu_pkg::vtag_t              tlb_vtag_o,
  input  logic                        tlb_hit_i,
  input  mmu_pkg::tlb_entry_t         tlb_entry_i,
  output logic                        resp_v_o,
  output mmu_pkg::paddr_t             resp_paddr_o,
  output logic                        resp_miss_o,
  output logic                        resp_load_page_fault_o,
  output logic                        resp_store_page_fault_o,
  output logic                        resp_access_fault_o,
  ptw_req_if.pipe                     ptw
);
  import mmu_pkg::*;

  logic   accept;
  logic   xlate;
  logic   hit;
  logic   priv_fault;
  logic   load_pf;
  logic   store_pf;
  logic   access_fault;
  logic   miss;
  paddr_t paddr;

  logic   resp_v_r;
  logic   miss_r;
  logic   load_pf_r;
  logic   store_pf_r;
  logic   access_fault_r;
  paddr_t paddr_r;
  vtag_t  vtag_r;
  logic   store_r;
  logic   walk_store_r;

  assign cmd_ready_o = ~ptw.busy;
  assign accept      = cmd_v_i & cmd_ready_o;
  assign tlb_vtag_o  = cmd_vaddr_i[VADDR_W-1:PAGE_OFFSET_W];

  assign xlate = satp_mode_i & (priv_i != priv_m);
  // sfence in the same cycle hides the old mapping
  assign hit   = tlb_hit_i & ~flush_i;

  assign priv_fault = ((priv_i == priv_s) & ~sum_i & tlb_entry_i.u)
                    | ((priv_i == priv_u) & ~tlb_entry_i.u);

  assign load_pf  = xlate & hit & ~cmd_store_i & priv_fault;
  assign store_pf = xlate & hit & cmd_store_i
                  & (priv_fault | ~tlb_entry_i.w | ~tlb_entry_i.d);
  assign access_fault = xlate & hit & ~load_pf & ~store_pf
                      & (|tlb_entry_i.ppn[PPN_W-1 -: DOMAIN_W]);
  assign miss = xlate & ~hit;

  always_comb begin
    if (!xlate) begin
      paddr = paddr_t'(cmd_vaddr_i);
    end else if (hit) begin
      paddr = {tlb_entry_i.ppn, cmd_vaddr_i[PAGE_OFFSET_W-1:0]};
    end else begin
      paddr = '0;
    end
  end

  // Walk faults never share a cycle with an accepted command
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_r       <= 1'b0;
      miss_r         <= 1'b0;
      load_pf_r      <= 1'b0;
      store_pf_r     <= 1'b0;
      access_fault_r <= 1'b0;
    end else if (ptw.fault_v) begin
      resp_v_r       <= 1'b1;
      miss_r         <= 1'b0;
      load_pf_r      <= ~walk_store_r;
      store_pf_r     <= walk_store_r;
      access_fault_r <= 1'b0;
    end else begin
      resp_v_r       <= accept;
      miss_r         <= accept & miss;
      load_pf_r      <= accept & load_pf;
      store_pf_r     <= accept & store_pf;
      access_fault_r <= accept & access_fault;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ptw.fault_v) begin
      paddr_r <= '0;
    end else if (accept) begin
      paddr_r <= paddr;
      vtag_r  <= tlb_vtag_o;
      store_r <= cmd_store_i;
    end
    // Kind of the walked access, for a later fault response
    if (ptw.miss_v) begin
      walk_store_r <= ptw.miss_store;
    end
  end

  assign ptw.miss_v     = resp_v_r & miss_r & ~ptw.busy;
  assign ptw.miss_vtag  = vtag_r;
  assign ptw.miss_store = store_r;

  assign resp_v_o                = resp_v_r;
  assign resp_paddr_o            = paddr_r;
  assign resp_miss_o             = miss_r;
  assign resp_load_page_fault_o  = load_pf_r;
  assign resp_store_page_fault_o = store_pf_r;
  assign resp_access_fault_o     = access_fault_r;

endmodule

// File: hw/ptw_fsm.sv
/*
 * Page table walker: request, wait, fill and fault states,
 * PTE address forming and PTE checks per level
 */
`timescale 1ns/1ps

module ptw_fsm (
  input  logic                clk_i,
  input  logic                reset_i,
  ptw_req_if.walker           walk,
  input  mmu_pkg::ppn_t       satp_ppn_i,
  output logic                walk_req_v_o,
  output mmu_pkg::paddr_t     walk_req_addr_o,
  input  logic                walk_resp_v_i,
  input  mmu_pkg::pte_t       walk_resp_data_i,
  output logic                fill_v_o,
  output mmu_pkg::vtag_t      fill_vtag_o,
  output mmu_pkg::tlb_entry_t fill_entry_o
);
  import mmu_pkg::*;

  typedef enum logic [2:0] {
    s_idle,
    s_req,
    s_wait,
    s_fill,
    s_fault
  } state_e;

  state_e               state_r;
  state_e               state_n;
  vtag_t                vtag_r;
  ppn_t                 base_r;
  tlb_entry_t           entry_r;
  level_t               level;
  logic                 last;
  logic                 start;
  logic                 step;
  logic                 pte_leaf;
  logic                 pte_fault;
  logic [VPN_SEG_W-1:0] vpn_seg;

  assign pte_leaf  = walk_resp_data_i.r | walk_resp_data_i.x;
  // Superpages are not supported, so only level 0 may hold a leaf
  assign pte_fault = ~walk_resp_data_i.v
                   | (walk_resp_data_i.w & ~walk_resp_data_i.r)
                   | (pte_leaf & ~last)
                   | (~pte_leaf & last);

  assign start = (state_r == s_idle) & walk.miss_v;
  assign step  = (state_r == s_wait) & walk_resp_v_i & ~pte_fault & ~pte_leaf;

  walk_level_counter i_level (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .start_i (start),
    .step_i  (step),
    .level_o (level),
    .last_o  (last)
  );

  always_comb begin
    state_n = state_r;
    case (state_r)
      s_idle: begin
        if (walk.miss_v) begin
          state_n = s_req;
        end
      end
      s_req: begin
        state_n = s_wait;
      end
      s_wait: begin
        if (walk_resp_v_i) begin
          if (pte_fault) begin
            state_n = s_fault;
          end else if (pte_leaf) begin
            state_n = s_fill;
          end else begin
            state_n = s_req;
          end
        end
      end
      default: begin
        state_n = s_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= s_idle;
    end else begin
      state_r <= state_n;
    end
  end

  // Walk context and leaf capture
  always_ff @(posedge clk_i) begin
    if (start) begin
      vtag_r <= walk.miss_vtag;
      base_r <= satp_ppn_i;
    end else if (step) begin
      base_r <= walk_resp_data_i.ppn;
    end
    if ((state_r == s_wait) && walk_resp_v_i) begin
      entry_r.ppn <= walk_resp_data_i.ppn;
      entry_r.u   <= walk_resp_data_i.u;
      entry_r.w   <= walk_resp_data_i.w;
      entry_r.d   <= walk_resp_data_i.d;
    end
  end

  assign vpn_seg         = vtag_r[level * VPN_SEG_W +: VPN_SEG_W];
  assign walk_req_addr_o = {base_r, vpn_seg, 2'b00};
  assign walk_req_v_o    = (state_r == s_req);

  assign fill_v_o     = (state_r == s_fill);
  assign fill_vtag_o  = vtag_r;
  assign fill_entry_o = entry_r;

  assign walk.busy    = (state_r != s_idle);
  assign walk.fault_v = (state_r == s_fault);

endmodule

// File: hw/walk_level_counter.sv
/*
 * Page table level counter for the walker
 */
`timescale 1ns/1ps

module walk_level_counter (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            start_i,
  input  logic            step_i,
  output mmu_pkg::level_t level_o,
  output logic            last_o
);
  import mmu_pkg::*;

  level_t level_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      level_r <= '0;
    end else if (start_i) begin
      level_r <= level_t'(PT_LEVELS - 1);
    end else if (step_i && (level_r != '0)) begin
      level_r <= level_r - 1'b1;
    end
  end

  assign level_o = level_r;
  assign last_o  = (level_r == '0);

endmodule

// File: hw/dtlb.sv
/*
 * Fully associative data TLB
 * Parallel tag compare, round-robin fill, flush of all entries
 */
`timescale 1ns/1ps

module dtlb #(
  parameter int TLB_ENTRIES = 4
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                flush_i,
  input  mmu_pkg::vtag_t      r_vtag_i,
  output logic                r_hit_o,
  output mmu_pkg::tlb_entry_t r_entry_o,
  input  logic                fill_v_i,
  input  mmu_pkg::vtag_t      fill_vtag_i,
  input  mmu_pkg::tlb_entry_t fill_entry_i
);
  import mmu_pkg::*;

  localparam int IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

  logic [TLB_ENTRIES-1:0] valid_r;
  vtag_t                  tag_r   [TLB_ENTRIES];
  tlb_entry_t             entry_r [TLB_ENTRIES];
  logic [IDX_W-1:0]       victim_r;
  logic [TLB_ENTRIES-1:0] match;

  // At most one slot holds a given tag
  always_comb begin
    r_entry_o = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      match[i] = valid_r[i] & (tag_r[i] == r_vtag_i);
      if (match[i]) begin
        r_entry_o = entry_r[i];
      end
    end
  end

  assign r_hit_o = |match;

  always_ff @(posedge clk_i) begin
    if (fill_v_i) begin
      tag_r[victim_r]   <= fill_vtag_i;
      entry_r[victim_r] <= fill_entry_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r  <= '0;
      victim_r <= '0;
    end else begin
      if (flush_i) begin
        valid_r <= '0;
      end
      // A fill in the flush cycle still lands
      if (fill_v_i) begin
        valid_r[victim_r] <= 1'b1;
        if (victim_r == IDX_W'(TLB_ENTRIES - 1)) begin
          victim_r <= '0;
        end else begin
          victim_r <= victim_r + 1'b1;
        end
      end
    end
  end

endmodule

// File: hw/ptw_req_if.sv
/*
 * Miss request and walk status link between the
 * translation pipeline and the page table walker
 */
`timescale 1ns/1ps

interface ptw_req_if;
  import mmu_pkg::*;

  logic  miss_v;
  vtag_t miss_vtag;
  logic  miss_store;
  logic  busy;
  logic  fault_v;

  modport pipe (
    output miss_v,
    output miss_vtag,
    output miss_store,
    input  busy,
    input  fault_v
  );

  modport walker (
    input  miss_v,
    input  miss_vtag,
    input  miss_store,
    output busy,
    output fault_v
  );

endinterface

// File: hw/mmu_pkg.sv
/*
 * MMU shared definitions: address and page table widths,
 * PTE and TLB entry layouts, privilege level encoding
 */
package mmu_pkg;

  localparam int VADDR_W       = 32;
  localparam int PADDR_W       = 34;
  localparam int PAGE_OFFSET_W = 12;
  localparam int VPN_SEG_W     = 10;
  localparam int PT_LEVELS     = 2;
  localparam int PPN_W         = 22;
  localparam int PTE_W         = 32;
  localparam int DOMAIN_W      = 2;

  localparam int VTAG_W  = VADDR_W - PAGE_OFFSET_W;
  localparam int LEVEL_W = $clog2(PT_LEVELS);

  typedef logic [VTAG_W-1:0]  vtag_t;
  typedef logic [PPN_W-1:0]   ppn_t;
  typedef logic [PADDR_W-1:0] paddr_t;
  typedef logic [LEVEL_W-1:0] level_t;

  // Sv32 style PTE, flags in the low byte
  typedef struct packed {
    ppn_t                     ppn;
    logic [PTE_W-PPN_W-9:0]   rsw;
    logic                     d;
    logic                     a;
    logic                     g;
    logic                     u;
    logic                     x;
    logic                     w;
    logic                     r;
    logic                     v;
  } pte_t;

  // Leaf fields kept per TLB slot
  typedef struct packed {
    ppn_t ppn;
    logic u;
    logic w;
    logic d;
  } tlb_entry_t;

  typedef enum logic [1:0] {
    priv_u = 2'd0,
    priv_s = 2'd1,
    priv_m = 2'd3
  } priv_e;

endpackage
